/* files.f */
+incdir+tb
hw/dfp_pkg.sv
hw/bin_to_bcd.sv
hw/dfp_axil_regs.sv
hw/dfp_req_fifo.sv
hw/dfp_int_convert.sv
hw/dfp_convert_top.sv
tb/dfp_convert_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dfp_convert_tb \
	-f files.f -o dfp_sim > build.log 2>&1 \
	&& ./obj_dir/dfp_sim > sim.log 2>&1
grep -q -F "Everything OK" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb/dfp_tb_tasks.svh */
// ==============================
// bus tasks
// ==============================

// full-word write, address and data go out together
task automatic write_reg(input logic [3:0] reg_addr, input logic [31:0] data);
	aw      <= '{addr: reg_addr};
	w       <= '{data: data, strb: 4'hF};
	awvalid <= 1'b1;
	wvalid  <= 1'b1;
	@(posedge clk);
	while (!(awready && wready))  // control writes may stall here
		@(posedge clk);
	awvalid <= 1'b0;  // handshake happened on this edge
	wvalid  <= 1'b0;
	@(posedge clk);
	while (!bvalid)  // bready stays high
		@(posedge clk);
	checks++;
	assert (b.resp == resp_okay) else begin
		$display("mismatch at %0t: write to %h answered resp %0d",
			$time, reg_addr, b.resp);
		errors++;
	end
endtask

task automatic read_reg(input logic [3:0] reg_addr, output logic [31:0] data,
		output logic [1:0] resp);
	ar      <= '{addr: reg_addr};
	arvalid <= 1'b1;
	@(posedge clk);
	while (!arready)
		@(posedge clk);
	arvalid <= 1'b0;
	@(posedge clk);
	while (!rvalid)  // rready stays high
		@(posedge clk);
	data = r.data;  // r is registered, stable at this edge
	resp = r.resp;
endtask

// ==============================
// dfp32 reference model
// ==============================
function automatic longint power_of_ten(input int k);
	longint p;
	p = 1;
	repeat (k)
		p = p * 10;
	return p;
endfunction

// value = significand d.ddddd * 10^(exp - bias), zero is the all-zero word
function automatic logic [31:0] expected_word(input logic [31:0] op, input logic is_signed,
		input logic [2:0] rm);
	logic            neg;
	logic            s;        // sticky below the round digit
	logic            inexact;
	logic            up;
	logic [6:0]      e;
	logic [31:0]     word;
	longint          mag;
	longint          t;
	longint          q;        // kept digits as a number
	longint          rem;
	longint          unit;     // weight of the first dropped digit
	int              n;
	int              rd;       // first dropped digit
	int              i;
	neg = is_signed && op[31];
	mag = neg ? -longint'($signed(op)) : longint'({32'd0, op});
	if (mag == 0)
		return 32'd0;
	n = 0;
	t = mag;
	while (t > 0) begin
		n++;
		t = t / 10;
	end
	rd = 0;
	s  = 1'b0;
	if (n <= sig_digits) begin
		q = mag * power_of_ten(sig_digits - n);  // exact, just shifted left
	end else begin
		q    = mag / power_of_ten(n - sig_digits);
		rem  = mag % power_of_ten(n - sig_digits);
		unit = power_of_ten(n - sig_digits - 1);
		rd   = int'(rem / unit);
		s    = (rem % unit) != 0;
	end
	inexact = rd != 0 || s;
	case (rm)
		rm_truncate: up = 1'b0;
		rm_up:       up = inexact && !neg;
		rm_down:     up = inexact && neg;
		rm_away:     up = inexact;
		default:     up = rd > 5 || (rd == 5 && (s || q % 2 == 1));  // ties to even
	endcase
	e = 7'(exp_bias + n - 1);
	if (up)
		q = q + 1;
	if (q == power_of_ten(sig_digits)) begin
		q = power_of_ten(sig_digits - 1);  // 999999 rolled over
		e = e + 7'd1;
	end
	word = {neg, e, 24'd0};
	for (i = 0; i < sig_digits; i++) begin
		word[4*i +: 4] = 4'(q % 10);
		q = q / 10;
	end
	return word;
endfunction

/* tb/dfp_convert_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dfp_convert_tb import dfp_pkg::*; ();

	localparam int timeout_cycles = 200 * 60 + 2000;

	logic     clk;
	logic     reset;
	axil_aw_t aw;
	logic     awvalid;
	logic     awready;
	axil_w_t  w;
	logic     wvalid;
	logic     wready;
	axil_b_t  b;
	logic     bvalid;
	logic     bready;
	axil_ar_t ar;
	logic     arvalid;
	logic     arready;
	axil_r_t  r;
	logic     rvalid;
	logic     rready;

	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] exp_q [$];  // expected words, oldest first

	`include "dfp_tb_tasks.svh"

	dfp_convert_top dut_i (
		.clk(clk), .reset(reset),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// operand first, then the control word queues it
	task automatic queue_request(input logic [31:0] op, input logic sgn, input logic [2:0] rm);
		write_reg(reg_operand, op);
		write_reg(reg_control, {28'd0, rm, sgn});
		exp_q.push_back(expected_word(op, sgn, rm));
	endtask

	task automatic check_next_result();
		logic [31:0] st;
		logic [31:0] data;
		logic [31:0] expected;
		logic [1:0]  resp;
		read_reg(reg_status, st, resp);
		while (!st[0])  // poll result valid
			read_reg(reg_status, st, resp);
		read_reg(reg_result, data, resp);
		expected = exp_q.pop_front();
		checks++;
		assert (resp == resp_okay && data == expected) else begin
			$display("mismatch at %0t: result expected %h, got %h resp %0d",
				$time, expected, data, resp);
			errors++;
		end
	endtask

	task automatic convert_one(input logic [31:0] op, input logic sgn, input logic [2:0] rm);
		queue_request(op, sgn, rm);
		check_next_result();
	endtask

	// ==============================
	// stimulus
	// ==============================
	initial begin
		logic [31:0] data;
		logic [1:0]  resp;
		logic [31:0] op;
		int          m;
		errors  = 0;
		checks  = 0;
		void'($urandom(8348));
		aw      = '0;
		awvalid = 1'b0;
		w       = '0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		ar      = '0;
		arvalid = 1'b0;
		rready  = 1'b1;
		reset   = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// idle state, nothing held
		read_reg(reg_status, data, resp);
		checks++;
		assert (data == 32'd0 && resp == resp_okay) else begin
			$display("mismatch at %0t: status after reset %h resp %0d", $time, data, resp);
			errors++;
		end
		read_reg(reg_result, data, resp);
		checks++;
		assert (data == 32'd0 && resp == resp_slverr) else begin
			$display("mismatch at %0t: empty result read %h resp %0d", $time, data, resp);
			errors++;
		end

		// exact values
		convert_one(32'd0, 1'b0, rm_nearest_even);
		convert_one(32'd7, 1'b0, rm_nearest_even);
		convert_one(32'd12345, 1'b0, rm_truncate);
		convert_one(32'd999999, 1'b0, rm_away);
		convert_one(32'd42, 1'b1, rm_nearest_even);      // signed but positive
		convert_one(32'hFFFF_FFD6, 1'b1, rm_nearest_even);  // -42
		convert_one(32'h8000_0000, 1'b0, rm_truncate);   // top bit, unsigned
		convert_one(32'h8000_0000, 1'b1, rm_truncate);   // most negative

		// rounding, mode 5 is undefined
		for (m = 0; m < 6; m++) begin
			convert_one(32'd1234565, 1'b0, 3'(m));   // tie, even last digit
			convert_one(32'd1234575, 1'b0, 3'(m));   // tie, odd last digit
			convert_one(32'd12345651, 1'b0, 3'(m));  // tie broken by sticky
			convert_one(32'd9999995, 1'b0, 3'(m));   // carry out
			convert_one(32'(-1234561), 1'b1, 3'(m));
		end

		// ==============================
		// back-pressure
		// ==============================
		// six requests fill holder, converter and queue
		for (m = 0; m < 6; m++)
			queue_request(32'(m * 1111111 + 7), 1'b0, rm_nearest_even);
		repeat (100) @(posedge clk);
		read_reg(reg_status, data, resp);
		checks++;
		assert (data[1:0] == 2'b11) else begin
			$display("mismatch at %0t: status with full queue %h", $time, data);
			errors++;
		end
		write_reg(reg_operand, 32'd77777777);
		exp_q.push_back(expected_word(32'd77777777, 1'b0, rm_away));
		fork
			write_reg(reg_control, {28'd0, rm_away, 1'b0});
			begin
				repeat (20) begin
					@(posedge clk);
					checks++;
					assert (!awready) else begin
						$display("control write was accepted while the queue was full");
						errors++;
					end
				end
				repeat (7)
					check_next_result();  // draining frees room for the stalled write
			end
		join

		// random operands, modes and signed flags
		for (m = 0; m < 150; m++) begin
			op = $urandom() >> ($urandom() % 32);  // spread over all digit counts
			convert_one(op, 1'($urandom()), 3'($urandom()));
		end

		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// run limit from the number of conversions
	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("errors: %0d in %0d checks", errors, checks);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/dfp_convert_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dfp_convert_top import dfp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	// write channels
	input  axil_aw_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  axil_w_t  w,
	input  logic     wvalid,
	output logic     wready,
	output axil_b_t  b,
	output logic     bvalid,
	input  logic     bready,
	// read channels
	input  axil_ar_t ar,
	input  logic     arvalid,
	output logic     arready,
	output axil_r_t  r,
	output logic     rvalid,
	input  logic     rready
);

	dfp_req_t push_req;    // register block -> queue
	logic     push_valid;
	logic     push_ready;
	dfp_req_t pop_req;     // queue -> converter
	logic     pop_valid;
	logic     pop_ready;
	dfp32_u   res;         // converter -> register block
	logic     res_valid;
	logic     res_ready;

	dfp_axil_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.aw        (aw),
		.awvalid   (awvalid),
		.awready   (awready),
		.w         (w),
		.wvalid    (wvalid),
		.wready    (wready),
		.b         (b),
		.bvalid    (bvalid),
		.bready    (bready),
		.ar        (ar),
		.arvalid   (arvalid),
		.arready   (arready),
		.r         (r),
		.rvalid    (rvalid),
		.rready    (rready),
		.req       (push_req),
		.req_valid (push_valid),
		.req_ready (push_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	dfp_req_fifo u_fifo (
		.clk       (clk),
		.reset     (reset),
		.in_data   (push_req),
		.in_valid  (push_valid),
		.in_ready  (push_ready),
		.out_data  (pop_req),
		.out_valid (pop_valid),
		.out_ready (pop_ready)
	);

	dfp_int_convert u_conv (
		.clk       (clk),
		.reset     (reset),
		.req       (pop_req),
		.req_valid (pop_valid),
		.req_ready (pop_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

endmodule

`default_nettype wire

/* hw/dfp_int_convert.sv */
`timescale 1ns/10ps
`default_nettype none

module dfp_int_convert import dfp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	// request side
	input  dfp_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	// result side
	output dfp32_u   res,
	output logic     res_valid,
	input  logic     res_ready
);

	typedef enum logic [2:0] {
		s_idle,   // waiting for a request
		s_load,   // magnitude into bin_to_bcd
		s_wait,   // bcd conversion running
		s_round,  // aligned digits held
		s_pack,   // rounded digits held
		s_out     // result offered
	} state_t;

	state_t                      state;
	dfp_req_t                    req_q;
	logic                        sign;
	logic [int_width-1:0]        mag;
	logic                        bcd_load;
	logic                        bcd_done;
	logic [4*bcd_digits-1:0]     bcd;

	// normalize
	logic [3:0]                  lz;       // leading zero digits
	logic                        lz_found;
	logic [3:0]                  n;        // significant digits
	logic [4*bcd_digits-1:0]     norm;     // leading digit at the top
	logic [exp_width-1:0]        exp_n;

	// aligned stage
	logic [sig_digits-1:0][3:0]  sig_a;
	logic [3:0]                  r_a;      // first dropped digit
	logic                        s_a;      // sticky, rest of the dropped digits
	logic [exp_width-1:0]        exp_a;
	logic                        zero_a;

	// round
	logic                        inexact;
	logic                        ne_up;
	logic                        rnd;
	logic [sig_digits-1:0][3:0]  sig_inc;
	logic                        carry;

	// rounded stage
	logic [sig_digits-1:0][3:0]  sig_r;
	logic [exp_width-1:0]        exp_r;
	logic                        zero_r;

	assign req_ready = state == s_idle;
	assign res_valid = state == s_out;

	// sign only counts for signed operands
	assign sign = req_q.is_signed && req_q.operand[int_width-1];
	assign mag  = sign ? -req_q.operand : req_q.operand;

	assign bcd_load = state == s_load;

	bin_to_bcd u_b2b (
		.clk   (clk),
		.reset (reset),
		.load  (bcd_load),
		.bin   (mag),
		.bcd   (bcd),
		.done  (bcd_done)
	);

	// ==============================
	// normalize
	// ==============================
	always_comb begin
		lz       = '0;
		lz_found = 1'b0;
		for (int i = bcd_digits - 1; i >= 0; i--) begin
			if (!lz_found && bcd[4*i +: 4] == 4'd0)
				lz = lz + 1'b1;
			else
				lz_found = 1'b1;
		end
	end

	assign n     = 4'(bcd_digits) - lz;        // zero input gives 0
	assign norm  = bcd << {lz, 2'b00};         // lz whole digits
	assign exp_n = exp_width'(exp_bias - 1) + exp_width'(n);

	// ==============================
	// round
	// ==============================
	assign inexact = (r_a != 4'd0) || s_a;
	// ties go to an even last digit
	assign ne_up = (r_a > 4'd5) || (r_a == 4'd5 && (s_a || sig_a[0][0]));

	always_comb begin
		case (req_q.rm)
			rm_nearest_even: rnd = ne_up;
			rm_truncate:     rnd = 1'b0;
			rm_up:           rnd = inexact && !sign;  // magnitude grows only for positives
			rm_down:         rnd = inexact && sign;
			rm_away:         rnd = inexact;
			default:         rnd = ne_up;
		endcase
	end

	// bcd increment, carry ripples through nines
	always_comb begin
		carry = rnd;
		for (int i = 0; i < sig_digits; i++) begin
			if (carry && sig_a[i] == 4'd9) begin
				sig_inc[i] = 4'd0;
			end else begin
				sig_inc[i] = sig_a[i] + {3'd0, carry};
				carry      = 1'b0;
			end
		end
	end

	// ==============================
	// control
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle:  if (req_valid) state <= s_load;
				s_load:  state <= s_wait;
				s_wait:  if (bcd_done) state <= s_round;
				s_round: state <= s_pack;
				s_pack:  state <= s_out;
				s_out:   if (res_ready) state <= s_idle;  // hold until taken
				default: state <= s_idle;
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clk) begin
		if (state == s_idle && req_valid)
			req_q <= req;
		if (state == s_wait && bcd_done) begin
			sig_a  <= norm[4*bcd_digits-1 -: 4*sig_digits];
			r_a    <= norm[4*(bcd_digits-sig_digits)-1 -: 4];
			s_a    <= |norm[4*(bcd_digits-sig_digits)-5:0];  // zero when n <= 6
			exp_a  <= exp_n;
			zero_a <= n == 4'd0;
		end
		if (state == s_round) begin
			zero_r <= zero_a;
			if (carry) begin
				// 999999 rolled over, renormalize to 100000
				sig_r                 <= '0;
				sig_r[sig_digits-1]   <= 4'd1;
				exp_r                 <= exp_a + 1'b1;
			end else begin
				sig_r <= sig_inc;
				exp_r <= exp_a;
			end
		end
		if (state == s_pack) begin
			if (zero_r) begin
				res.raw <= '0;  // zero is the all-zero word
			end else begin
				res.f.sign <= sign;
				res.f.exp  <= exp_r;
				res.f.sig  <= sig_r;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/dfp_req_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module dfp_req_fifo import dfp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	// push side
	input  dfp_req_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	// pop side
	output dfp_req_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	dfp_req_t                        mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0]   wr_ptr;  // wraps on its own, depth is a power of two
	logic [$clog2(fifo_depth)-1:0]   rd_ptr;
	logic [$clog2(fifo_depth):0]     count;   // 0..fifo_depth
	logic                            push;
	logic                            pop;

	assign in_ready  = count != ($clog2(fifo_depth) + 1)'(fifo_depth);
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];  // head entry

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;  // both or neither, occupancy unchanged
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

endmodule

`default_nettype wire

/* hw/dfp_axil_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module dfp_axil_regs import dfp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	// write channels
	input  axil_aw_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  axil_w_t  w,
	input  logic     wvalid,
	output logic     wready,
	output axil_b_t  b,
	output logic     bvalid,
	input  logic     bready,
	// read channels
	input  axil_ar_t ar,
	input  logic     arvalid,
	output logic     arready,
	output axil_r_t  r,
	output logic     rvalid,
	input  logic     rready,
	// request push
	output dfp_req_t req,
	output logic     req_valid,
	input  logic     req_ready,
	// result in
	input  dfp32_u   res,
	input  logic     res_valid,
	output logic     res_ready
);

	logic [int_width-1:0] operand;     // last written operand
	dfp32_u               hold;        // one-deep result holder
	logic                 hold_valid;
	logic                 ctl_sel;     // write targets the control register
	logic                 full_word;   // only full-word writes update registers
	logic                 wr_start;
	logic                 wr_fire;
	logic                 rd_start;
	logic                 rd_fire;
	logic [31:0]          rd_data;
	logic [1:0]           rd_resp;

	// ==============================
	// write path
	// ==============================
	assign ctl_sel   = aw.addr == reg_control;
	assign full_word = &w.strb;

	// both channels together, no response outstanding,
	// control writes stall while the queue has no room
	assign wr_start = awvalid && wvalid && !awready && !bvalid && (!ctl_sel || req_ready);
	assign wr_fire  = awvalid && awready && wvalid && wready;

	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			awready <= wr_start;  // one-cycle ready pulse
			wready  <= wr_start;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	assign b = '{resp: resp_okay};  // every write completes

	always_ff @(posedge clk) begin
		if (wr_fire && full_word && aw.addr == reg_operand)
			operand <= w.data;
	end

	// control write pushes straight into the queue on the handshake cycle,
	// room was checked when the write was accepted
	assign req.operand   = operand;
	assign req.is_signed = w.data[ctl_signed_bit];
	assign req.rm        = w.data[ctl_rm_lsb +: 3];
	assign req_valid     = wr_fire && full_word && ctl_sel;

	// ==============================
	// result holder
	// ==============================
	assign res_ready = !hold_valid;

	always_ff @(posedge clk) begin
		if (reset)
			hold_valid <= 1'b0;
		else if (rd_fire && ar.addr == reg_result && hold_valid)
			hold_valid <= 1'b0;  // read frees it
		else if (res_valid && res_ready)
			hold_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (res_valid && res_ready)
			hold <= res;
	end

	// ==============================
	// read path
	// ==============================
	assign rd_start = arvalid && !arready && !rvalid;
	assign rd_fire  = arvalid && arready;

	always_comb begin
		rd_data = '0;
		rd_resp = resp_okay;  // unmapped addresses read as zero
		case (ar.addr)
			reg_status: rd_data = {30'd0, !req_ready, hold_valid};
			reg_result: begin
				if (hold_valid)
					rd_data = hold.raw;
				else
					rd_resp = resp_slverr;  // nothing to read
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= rd_start;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			r <= '{data: rd_data, resp: rd_resp};
	end

endmodule

`default_nettype wire

/* hw/bin_to_bcd.sv */
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd import dfp_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load,
	input  logic [int_width-1:0]    bin,
	output logic [4*bcd_digits-1:0] bcd,
	output logic                    done
);

	logic [int_width-1:0]    sh;    // binary bits not yet shifted in
	logic [4*bcd_digits-1:0] adj;   // digits after the add-3 step
	logic [4:0]              cnt;   // shifts done after the load shift
	logic                    busy;

	// double dabble, any digit >= 5 gets +3 before the shift
	always_comb begin
		for (int i = 0; i < bcd_digits; i++) begin
			if (bcd[4*i +: 4] >= 4'd5)
				adj[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
			else
				adj[4*i +: 4] = bcd[4*i +: 4];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else if (load) begin
			busy <= 1'b1;
			done <= 1'b0;  // result no longer stable
			cnt  <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			// load edge did the first shift, 31 more here
			if (cnt == 5'(int_width - 2)) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			bcd <= (4*bcd_digits)'(bin[int_width-1]);  // msb goes in right away
			sh  <= bin << 1;
		end else if (busy) begin
			bcd <= {adj[4*bcd_digits-2:0], sh[int_width-1]};
			sh  <= sh << 1;
		end
	end

endmodule

`default_nettype wire

/* hw/dfp_pkg.sv */
`default_nettype none

package dfp_pkg;

	// ==============================
	// dfp32 format
	// ==============================
	localparam int int_width  = 32;  // operand width
	localparam int bcd_digits = 10;  // digits out of the binary to bcd step
	localparam int sig_digits = 6;   // significand digits, read as d.ddddd
	localparam int exp_width  = 7;
	localparam int exp_bias   = 64;

	// ==============================
	// register map
	// ==============================
	localparam logic [3:0] reg_operand = 4'h0;  // write only
	localparam logic [3:0] reg_control = 4'h4;  // a write queues a request
	localparam logic [3:0] reg_status  = 4'h8;  // bit 0 result valid, bit 1 queue full
	localparam logic [3:0] reg_result  = 4'hC;  // read pops the held result

	// control word layout
	localparam int ctl_signed_bit = 0;  // 1 = operand is two's complement
	localparam int ctl_rm_lsb     = 1;  // rounding mode in bits 3:1

	// rounding modes, 5..7 fall back to nearest even
	localparam logic [2:0] rm_nearest_even = 3'd0;
	localparam logic [2:0] rm_truncate     = 3'd1;
	localparam logic [2:0] rm_up           = 3'd2;  // toward +inf
	localparam logic [2:0] rm_down         = 3'd3;  // toward -inf
	localparam logic [2:0] rm_away         = 3'd4;  // away from zero

	localparam int fifo_depth = 4;  // request queue entries

	// axi responses
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// ==============================
	// types
	// ==============================
	typedef struct packed {
		logic [int_width-1:0] operand;
		logic                 is_signed;
		logic [2:0]           rm;
	} dfp_req_t;

	typedef struct packed {
		logic                          sign;
		logic [exp_width-1:0]          exp;  // biased by exp_bias
		logic [sig_digits-1:0][3:0]    sig;  // digit 5 is the leading one
	} dfp32_fields_t;

	// converter fills the fields, the bus side only sees a word
	typedef union packed {
		logic [31:0]   raw;
		dfp32_fields_t f;
	} dfp32_u;

	typedef struct packed {
		logic [3:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [3:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

endpackage

`default_nettype wire
